// ==== hw/or_isa_pkg.sv ====
package or_isa_pkg;

	localparam int insn_w = 32;

	typedef logic [5:0] opcode_t;
	typedef logic [4:0] reg_addr_t;

	//////////////////////////////////////////////////////////////////////
	// major opcodes, bits 31:26
	localparam opcode_t OP_J     = 6'h00;
	localparam opcode_t OP_JAL   = 6'h01;
	localparam opcode_t OP_BNF   = 6'h03;
	localparam opcode_t OP_BF    = 6'h04;
	localparam opcode_t OP_NOP   = 6'h05;
	localparam opcode_t OP_MOVHI = 6'h06;
	localparam opcode_t OP_XSYNC = 6'h08;
	localparam opcode_t OP_RFE   = 6'h09;
	localparam opcode_t OP_JR    = 6'h11;
	localparam opcode_t OP_JALR  = 6'h12;
	localparam opcode_t OP_LWZ   = 6'h21;
	localparam opcode_t OP_LWS   = 6'h22;
	localparam opcode_t OP_LBZ   = 6'h23;
	localparam opcode_t OP_LBS   = 6'h24;
	localparam opcode_t OP_LHZ   = 6'h25;
	localparam opcode_t OP_LHS   = 6'h26;
	localparam opcode_t OP_ADDI  = 6'h27;
	localparam opcode_t OP_ADDIC = 6'h28;
	localparam opcode_t OP_ANDI  = 6'h29;
	localparam opcode_t OP_ORI   = 6'h2a;
	localparam opcode_t OP_XORI  = 6'h2b;
	localparam opcode_t OP_MFSPR = 6'h2d;
	localparam opcode_t OP_SFXXI = 6'h2f;
	localparam opcode_t OP_MTSPR = 6'h30;
	localparam opcode_t OP_SW    = 6'h35;
	localparam opcode_t OP_SB    = 6'h36;
	localparam opcode_t OP_SH    = 6'h37;
	localparam opcode_t OP_ALU   = 6'h38;
	localparam opcode_t OP_SFXX  = 6'h39;

	// alu function codes with no unit behind them
	localparam logic [4:0] ALUFN_MUL   = 5'h06;
	localparam logic [4:0] ALUFN_SHROT = 5'h08;
	localparam logic [4:0] ALUFN_DIV   = 5'h09;
	localparam logic [4:0] ALUFN_DIVU  = 5'h0a;
	localparam logic [3:0] SHROT_ROR   = 4'h3;

	// one word, two ways of looking at it
	typedef union packed {
		struct packed {
			opcode_t   opcode;
			reg_addr_t rd;
			reg_addr_t ra;
			logic [15:0] imm;
		} imm_f;
		struct packed {
			opcode_t   opcode;
			reg_addr_t rd;
			reg_addr_t ra;
			reg_addr_t rb;
			logic      rsv10;
			logic [3:0] op2;
			logic      rsv5;
			logic [4:0] func;
		} reg_f;
	} insn_u;

	// bit 16 marks a bubble rather than a real l.nop
	localparam logic [insn_w-1:0] nop_insn = {OP_NOP, 26'h041_0000};

endpackage

// ==== hw/or_ctrl_pkg.sv ====
package or_ctrl_pkg;

	//////////////////////////////////////////////////////////////////////
	// branch unit ops
	typedef logic [2:0] branch_op_t;
	localparam branch_op_t BR_NOP = 3'd0;
	localparam branch_op_t BR_J   = 3'd1;
	localparam branch_op_t BR_JR  = 3'd2;
	localparam branch_op_t BR_BF  = 3'd4;
	localparam branch_op_t BR_BNF = 3'd5;
	localparam branch_op_t BR_RFE = 3'd6;

	// alu ops, low codes match the ALU function field
	typedef logic [4:0] alu_op_t;
	localparam alu_op_t ALUOP_ADD   = 5'd0;
	localparam alu_op_t ALUOP_ADDC  = 5'd1;
	localparam alu_op_t ALUOP_AND   = 5'd3;
	localparam alu_op_t ALUOP_OR    = 5'd4;
	localparam alu_op_t ALUOP_XOR   = 5'd5;
	localparam alu_op_t ALUOP_NOP   = 5'd4;
	localparam alu_op_t ALUOP_MOVHI = 5'd16;
	localparam alu_op_t ALUOP_COMP  = 5'd17;

	// writeback op is {source, write enable}
	typedef logic [2:0] rfwb_op_t;
	localparam rfwb_op_t RFWB_NOP = 3'b000;
	localparam logic [1:0] RFWB_SRC_ALU  = 2'd0;
	localparam logic [1:0] RFWB_SRC_LSU  = 2'd1;
	localparam logic [1:0] RFWB_SRC_SPRS = 2'd2;
	localparam logic [1:0] RFWB_SRC_LR   = 2'd3;

	typedef logic [3:0] lsu_op_t;
	localparam lsu_op_t LSU_NOP = 4'b0000;
	localparam lsu_op_t LSU_LBZ = 4'b0010;
	localparam lsu_op_t LSU_LBS = 4'b0011;
	localparam lsu_op_t LSU_LHZ = 4'b0100;
	localparam lsu_op_t LSU_LHS = 4'b0101;
	localparam lsu_op_t LSU_LWZ = 4'b0110;
	localparam lsu_op_t LSU_LWS = 4'b0111;
	localparam lsu_op_t LSU_SB  = 4'b1010;
	localparam lsu_op_t LSU_SH  = 4'b1100;
	localparam lsu_op_t LSU_SW  = 4'b1110;

	// operand muxes in front of the ALU
	typedef logic [1:0] sel_t;
	localparam sel_t SEL_RF      = 2'd0;
	localparam sel_t SEL_IMM     = 2'd1;
	localparam sel_t SEL_EX_FORW = 2'd2;
	localparam sel_t SEL_WB_FORW = 2'd3;

	localparam logic [4:0] link_reg = 5'd9;

endpackage

// ==== hw/insn_pipe.sv ====
`timescale 1ns/1ps

module insn_pipe (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [or_isa_pkg::insn_w-1:0]   if_insn,
	input  logic                            id_freeze,
	input  logic                            ex_freeze,
	input  logic                            wb_freeze,
	input  logic                            flushpipe,
	output or_isa_pkg::insn_u               id_insn,
	output or_isa_pkg::insn_u               ex_insn,
	output or_isa_pkg::insn_u               wb_insn,
	output logic                            id_void,
	output logic                            ex_void
);
	import or_isa_pkg::*;

	logic ex_bubble;

	// EX gets a bubble when ID stalls under a running EX, or on flush
	assign ex_bubble = (!ex_freeze && id_freeze) || flushpipe;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			id_insn <= nop_insn;
		else if (flushpipe)
			id_insn <= nop_insn;
		else if (!id_freeze)
			id_insn <= if_insn;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ex_insn <= nop_insn;
		else if (ex_bubble)
			ex_insn <= nop_insn;
		else if (!ex_freeze)
			ex_insn <= id_insn;
	end

	// writeback keeps the retired word even across a flush
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wb_insn <= nop_insn;
		else if (!wb_freeze)
			wb_insn <= ex_insn;
	end

	assign id_void = (id_insn.imm_f.opcode == OP_NOP) && id_insn[16];
	assign ex_void = (ex_insn.imm_f.opcode == OP_NOP) && ex_insn[16];

endmodule

// ==== hw/branch_ctrl.sv ====
`timescale 1ns/1ps

module branch_ctrl (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [or_isa_pkg::insn_w-1:0]   if_insn,
	input  or_isa_pkg::insn_u               id_insn,
	input  logic [31:0]                     id_pc,
	input  logic                            id_freeze,
	input  logic                            ex_freeze,
	input  logic                            flushpipe,
	input  logic                            ex_branch_taken,
	input  logic                            id_void,
	output or_ctrl_pkg::branch_op_t         id_branch_op,
	output or_ctrl_pkg::branch_op_t         ex_branch_op,
	output logic [31:2]                     id_branch_addrtarget,
	output logic [31:2]                     ex_branch_addrtarget,
	output logic                            no_more_dslot,
	output logic                            rfe
);
	import or_isa_pkg::*;
	import or_ctrl_pkg::*;

	opcode_t if_opc;
	logic    ex_bubble;

	assign if_opc    = if_insn[31:26];
	assign ex_bubble = (!ex_freeze && id_freeze) || flushpipe;

	//////////////////////////////////////////////////////////////////////
	// branch op, decoded from the fetched word alongside the ID latch
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			id_branch_op <= BR_NOP;
		else if (flushpipe)
			id_branch_op <= BR_NOP;
		else if (!id_freeze) begin
			case (if_opc)
				OP_J, OP_JAL:   id_branch_op <= BR_J;
				OP_JR, OP_JALR: id_branch_op <= BR_JR;
				OP_BNF:         id_branch_op <= BR_BNF;
				OP_BF:          id_branch_op <= BR_BF;
				OP_RFE:         id_branch_op <= BR_RFE;
				default:        id_branch_op <= BR_NOP;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ex_branch_op <= BR_NOP;
		else if (ex_bubble)
			ex_branch_op <= BR_NOP;
		else if (!ex_freeze)
			ex_branch_op <= id_branch_op;
	end

	//////////////////////////////////////////////////////////////////////
	// word-aligned target, 26 bit offset sign extended
	assign id_branch_addrtarget = {{4{id_insn[25]}}, id_insn[25:0]} + id_pc[31:2];

	always_ff @(posedge clk) begin
		if (!ex_freeze)
			ex_branch_addrtarget <= id_branch_addrtarget;
	end

	// stop delay slot fetch once a taken branch has its slot in ID
	assign no_more_dslot = ((ex_branch_op != BR_NOP) && ex_branch_taken && !id_void) ||
		(ex_branch_op == BR_RFE);

	assign rfe = (id_branch_op == BR_RFE) || (ex_branch_op == BR_RFE);

endmodule

// ==== hw/id_decode.sv ====
`timescale 1ns/1ps

module id_decode (
	input  logic                         clk,
	input  logic                         rst_n,
	input  or_isa_pkg::insn_u            id_insn,
	input  logic                         id_freeze,
	input  logic                         ex_freeze,
	input  logic                         flushpipe,
	input  logic                         abort_mvspr,
	input  logic                         du_hwbkpt,
	output logic [31:0]                  id_simm,
	output logic [31:0]                  ex_simm,
	output or_ctrl_pkg::lsu_op_t         id_lsu_op,
	output or_ctrl_pkg::alu_op_t         alu_op,
	output logic [3:0]                   alu_op2,
	output logic [3:0]                   comp_op,
	output or_ctrl_pkg::rfwb_op_t        rfwb_op,
	output or_isa_pkg::reg_addr_t        rf_addrw,
	output logic                         ex_spr_read,
	output logic                         ex_spr_write,
	output logic                         except_illegal,
	output logic                         sig_syscall,
	output logic                         sig_trap
);
	import or_isa_pkg::*;
	import or_ctrl_pkg::*;

	opcode_t     opc;
	logic [15:0] split_imm;
	logic        ex_bubble;
	alu_op_t     alu_d;
	rfwb_op_t    rfwb_d;
	logic        illegal_d;
	logic        spr_read;
	logic        spr_write;

	assign opc       = id_insn.imm_f.opcode;
	assign ex_bubble = (!ex_freeze && id_freeze) || flushpipe;

	// stores and mtspr carry their immediate around the rb field
	assign split_imm = {id_insn.reg_f.rd, id_insn.reg_f.rsv10, id_insn.reg_f.op2,
		id_insn.reg_f.rsv5, id_insn.reg_f.func};

	//////////////////////////////////////////////////////////////////////
	// ID stage, combinational
	always_comb begin
		case (opc)
			OP_ADDI, OP_ADDIC, OP_XORI, OP_SFXXI,
			OP_LWZ, OP_LWS, OP_LBZ, OP_LBS, OP_LHZ, OP_LHS:
				id_simm = {{16{id_insn.imm_f.imm[15]}}, id_insn.imm_f.imm};
			OP_SW, OP_SB, OP_SH:
				id_simm = {{16{split_imm[15]}}, split_imm};
			OP_MTSPR:
				id_simm = {16'h0000, split_imm};
			default:
				id_simm = {16'h0000, id_insn.imm_f.imm};
		endcase
	end

	always_comb begin
		case (opc)
			OP_LWZ:  id_lsu_op = LSU_LWZ;
			OP_LWS:  id_lsu_op = LSU_LWS;
			OP_LBZ:  id_lsu_op = LSU_LBZ;
			OP_LBS:  id_lsu_op = LSU_LBS;
			OP_LHZ:  id_lsu_op = LSU_LHZ;
			OP_LHS:  id_lsu_op = LSU_LHS;
			OP_SW:   id_lsu_op = LSU_SW;
			OP_SB:   id_lsu_op = LSU_SB;
			OP_SH:   id_lsu_op = LSU_SH;
			default: id_lsu_op = LSU_NOP;
		endcase
	end

	// next EX ops
	always_comb begin
		alu_d  = ALUOP_NOP;
		rfwb_d = RFWB_NOP;
		case (opc)
			OP_JAL, OP_JALR: rfwb_d = {RFWB_SRC_LR, 1'b1};
			OP_MFSPR:        rfwb_d = {RFWB_SRC_SPRS, 1'b1};
			OP_LWZ, OP_LWS, OP_LBZ, OP_LBS, OP_LHZ, OP_LHS:
				rfwb_d = {RFWB_SRC_LSU, 1'b1};
			OP_MOVHI: begin
				alu_d  = ALUOP_MOVHI;
				rfwb_d = {RFWB_SRC_ALU, 1'b1};
			end
			OP_ADDI, OP_ADDIC, OP_ANDI, OP_ORI, OP_XORI: begin
				case (opc)
					OP_ADDI:  alu_d = ALUOP_ADD;
					OP_ADDIC: alu_d = ALUOP_ADDC;
					OP_ANDI:  alu_d = ALUOP_AND;
					OP_ORI:   alu_d = ALUOP_OR;
					default:  alu_d = ALUOP_XOR;
				endcase
				rfwb_d = {RFWB_SRC_ALU, 1'b1};
			end
			OP_ALU: begin
				alu_d  = {1'b0, id_insn.reg_f.func[3:0]};
				rfwb_d = {RFWB_SRC_ALU, 1'b1};
			end
			OP_SFXX, OP_SFXXI: alu_d = ALUOP_COMP;
			default: ;
		endcase
	end

	// no multiplier, divider or rotator behind the ALU
	always_comb begin
		case (opc)
			OP_J, OP_JAL, OP_JR, OP_JALR, OP_BNF, OP_BF, OP_RFE, OP_NOP,
			OP_MOVHI, OP_MFSPR, OP_MTSPR, OP_XSYNC,
			OP_LWZ, OP_LWS, OP_LBZ, OP_LBS, OP_LHZ, OP_LHS,
			OP_ADDI, OP_ADDIC, OP_ANDI, OP_ORI, OP_XORI,
			OP_SFXXI, OP_SFXX, OP_SW, OP_SB, OP_SH:
				illegal_d = 1'b0;
			OP_ALU:
				illegal_d = (id_insn.reg_f.func == ALUFN_DIV) ||
					(id_insn.reg_f.func == ALUFN_DIVU) ||
					(id_insn.reg_f.func == ALUFN_MUL) ||
					((id_insn.reg_f.func == ALUFN_SHROT) &&
					(id_insn.reg_f.op2 == SHROT_ROR));
			default:
				illegal_d = 1'b1;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// EX stage registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			alu_op         <= ALUOP_NOP;
			alu_op2        <= 4'd0;
			comp_op        <= 4'd0;
			rfwb_op        <= RFWB_NOP;
			rf_addrw       <= 5'd0;
			spr_read       <= 1'b0;
			spr_write      <= 1'b0;
			except_illegal <= 1'b0;
			sig_syscall    <= 1'b0;
			sig_trap       <= 1'b0;
		end else if (ex_bubble) begin
			alu_op         <= ALUOP_NOP;
			alu_op2        <= 4'd0;
			comp_op        <= 4'd0;
			rfwb_op        <= RFWB_NOP;
			rf_addrw       <= 5'd0;
			spr_read       <= 1'b0;
			spr_write      <= 1'b0;
			except_illegal <= 1'b0;
			sig_syscall    <= 1'b0;
			sig_trap       <= 1'b0;
		end else if (!ex_freeze) begin
			alu_op         <= alu_d;
			alu_op2        <= id_insn.reg_f.op2;
			comp_op        <= id_insn.reg_f.rd[3:0];
			rfwb_op        <= rfwb_d;
			rf_addrw       <= (opc == OP_JAL || opc == OP_JALR) ? link_reg : id_insn.reg_f.rd;
			spr_read       <= (opc == OP_MFSPR);
			spr_write      <= (opc == OP_MTSPR);
			except_illegal <= illegal_d;
			sig_syscall    <= (opc == OP_XSYNC) && (id_insn.reg_f.rd[4:2] == 3'b000);
			sig_trap       <= ((opc == OP_XSYNC) && (id_insn.reg_f.rd[4:2] == 3'b010)) ||
				du_hwbkpt;
		end
	end

	always_ff @(posedge clk) begin
		if (!ex_freeze)
			ex_simm <= id_simm;
	end

	// an aborted l.mfspr/l.mtspr must not reach the SPR bus
	assign ex_spr_read  = spr_read && !abort_mvspr;
	assign ex_spr_write = spr_write && !abort_mvspr;

endmodule

// ==== hw/operand_forward.sv ====
`timescale 1ns/1ps

module operand_forward (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [or_isa_pkg::insn_w-1:0]   if_insn,
	input  or_isa_pkg::insn_u               id_insn,
	input  logic                            id_freeze,
	input  logic                            wb_freeze,
	input  or_isa_pkg::reg_addr_t           rf_addrw,
	input  or_ctrl_pkg::rfwb_op_t           rfwb_op,
	input  logic                            wbforw_valid,
	output or_ctrl_pkg::sel_t               sel_a,
	output or_ctrl_pkg::sel_t               sel_b,
	output or_isa_pkg::reg_addr_t           rf_addra,
	output or_isa_pkg::reg_addr_t           rf_addrb,
	output logic                            rf_rda,
	output logic                            rf_rdb
);
	import or_isa_pkg::*;
	import or_ctrl_pkg::*;

	insn_u     if_word;
	logic      sel_imm;
	reg_addr_t wb_rfaddrw;

	assign if_word = if_insn;

	// register file is read straight from the fetched word
	assign rf_addra = if_word.reg_f.ra;
	assign rf_addrb = if_word.reg_f.rb;
	assign rf_rda   = if_insn[31];
	assign rf_rdb   = if_insn[30];

	// b operand comes from the immediate for everything not listed
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			sel_imm <= 1'b0;
		else if (!id_freeze) begin
			case (if_word.reg_f.opcode)
				OP_JALR, OP_JR, OP_RFE, OP_MFSPR, OP_MTSPR, OP_XSYNC,
				OP_SW, OP_SB, OP_SH, OP_ALU, OP_SFXX, OP_NOP:
					sel_imm <= 1'b0;
				default:
					sel_imm <= 1'b1;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wb_rfaddrw <= 5'd0;
		else if (!wb_freeze)
			wb_rfaddrw <= rf_addrw;
	end

	//////////////////////////////////////////////////////////////////////
	// EX result wins over WB result
	always_comb begin
		if ((id_insn.reg_f.ra == rf_addrw) && rfwb_op[0])
			sel_a = SEL_EX_FORW;
		else if ((id_insn.reg_f.ra == wb_rfaddrw) && wbforw_valid)
			sel_a = SEL_WB_FORW;
		else
			sel_a = SEL_RF;
	end

	always_comb begin
		if (sel_imm)
			sel_b = SEL_IMM;
		else if ((id_insn.reg_f.rb == rf_addrw) && rfwb_op[0])
			sel_b = SEL_EX_FORW;
		else if ((id_insn.reg_f.rb == wb_rfaddrw) && wbforw_valid)
			sel_b = SEL_WB_FORW;
		else
			sel_b = SEL_RF;
	end

endmodule

// ==== hw/decode_ctrl_top.sv ====
`timescale 1ns/1ps

module decode_ctrl_top (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [or_isa_pkg::insn_w-1:0]   if_insn,
	input  logic [31:0]                     id_pc,
	input  logic                            id_freeze,
	input  logic                            ex_freeze,
	input  logic                            wb_freeze,
	input  logic                            ex_branch_taken,
	input  logic                            abort_mvspr,
	input  logic                            du_hwbkpt,
	input  logic                            wbforw_valid,
	input  logic                            except_flushpipe,
	input  logic                            pc_we,
	input  logic                            extend_flush,
	input  logic                            du_flush_pipe,
	output logic                            flushpipe,
	output or_isa_pkg::insn_u               id_insn,
	output or_isa_pkg::insn_u               ex_insn,
	output or_isa_pkg::insn_u               wb_insn,
	output logic                            id_void,
	output logic                            ex_void,
	output or_ctrl_pkg::branch_op_t         id_branch_op,
	output or_ctrl_pkg::branch_op_t         ex_branch_op,
	output logic [31:2]                     id_branch_addrtarget,
	output logic [31:2]                     ex_branch_addrtarget,
	output logic                            no_more_dslot,
	output logic                            rfe,
	output logic [31:0]                     id_simm,
	output logic [31:0]                     ex_simm,
	output or_ctrl_pkg::lsu_op_t            id_lsu_op,
	output or_ctrl_pkg::alu_op_t            alu_op,
	output logic [3:0]                      alu_op2,
	output logic [3:0]                      comp_op,
	output or_ctrl_pkg::rfwb_op_t           rfwb_op,
	output or_isa_pkg::reg_addr_t           rf_addrw,
	output logic                            ex_spr_read,
	output logic                            ex_spr_write,
	output logic                            except_illegal,
	output logic                            sig_syscall,
	output logic                            sig_trap,
	output or_ctrl_pkg::sel_t               sel_a,
	output or_ctrl_pkg::sel_t               sel_b,
	output or_isa_pkg::reg_addr_t           rf_addra,
	output or_isa_pkg::reg_addr_t           rf_addrb,
	output logic                            rf_rda,
	output logic                            rf_rdb
);

	// every stage flushes on the same merged request
	assign flushpipe = except_flushpipe | pc_we | extend_flush | du_flush_pipe;

	insn_pipe u_insn_pipe (.*);

	branch_ctrl u_branch_ctrl (.*);

	id_decode u_id_decode (.*);

	operand_forward u_operand_forward (.*);

endmodule

// ==== tb/decode_ctrl_tb.sv ====
`timescale 1ns/1ps

module decode_ctrl_tb;
	import or_isa_pkg::*;
	import or_ctrl_pkg::*;

	typedef struct packed {
		alu_op_t     alu_op;
		rfwb_op_t    rfwb_op;
		reg_addr_t   rf_addrw;
		logic [31:0] simm;
		lsu_op_t     lsu_op;
		logic        illegal;
		logic        syscall;
		logic        trap;
	} expect_t;

	localparam opcode_t kept_ops [29] = '{
		OP_J, OP_JAL, OP_BNF, OP_BF, OP_NOP, OP_MOVHI, OP_XSYNC, OP_RFE, OP_JR, OP_JALR,
		OP_LWZ, OP_LWS, OP_LBZ, OP_LBS, OP_LHZ, OP_LHS, OP_ADDI, OP_ADDIC, OP_ANDI,
		OP_ORI, OP_XORI, OP_MFSPR, OP_SFXXI, OP_MTSPR, OP_SW, OP_SB, OP_SH, OP_ALU, OP_SFXX
	};
	localparam opcode_t br_ops [8] = '{
		OP_J, OP_JAL, OP_JR, OP_JALR, OP_BNF, OP_BF, OP_RFE, OP_ADDI
	};

	// fixed words for the directed tests
	localparam logic [31:0] addi_w  = {OP_ADDI, 5'd5, 5'd1, 16'h0001};
	localparam logic [31:0] ori_w   = {OP_ORI, 5'd8, 5'd9, 16'h00f0};
	localparam logic [31:0] xori_w  = {OP_XORI, 5'd10, 5'd11, 16'h8003};
	localparam logic [31:0] alu1_w  = {OP_ALU, 5'd6, 5'd5, 5'd2, 6'h00, 5'h00};
	localparam logic [31:0] alu2_w  = {OP_ALU, 5'd7, 5'd5, 5'd3, 6'h00, 5'h00};
	localparam logic [31:0] mfspr_w = {OP_MFSPR, 5'd4, 5'd0, 16'h0011};
	localparam logic [31:0] mtspr_w = {OP_MTSPR, 5'd0, 5'd3, 5'd4, 11'h022};

	logic clk;
	logic rst_n;
	logic [31:0] if_insn;
	logic [31:0] id_pc;
	logic id_freeze;
	logic ex_freeze;
	logic wb_freeze;
	logic ex_branch_taken;
	logic abort_mvspr;
	logic du_hwbkpt;
	logic wbforw_valid;
	logic except_flushpipe;
	logic pc_we;
	logic extend_flush;
	logic du_flush_pipe;
	logic flushpipe;
	insn_u id_insn;
	insn_u ex_insn;
	insn_u wb_insn;
	logic id_void;
	logic ex_void;
	branch_op_t id_branch_op;
	branch_op_t ex_branch_op;
	logic [31:2] id_branch_addrtarget;
	logic [31:2] ex_branch_addrtarget;
	logic no_more_dslot;
	logic rfe;
	logic [31:0] id_simm;
	logic [31:0] ex_simm;
	lsu_op_t id_lsu_op;
	alu_op_t alu_op;
	logic [3:0] alu_op2;
	logic [3:0] comp_op;
	rfwb_op_t rfwb_op;
	reg_addr_t rf_addrw;
	logic ex_spr_read;
	logic ex_spr_write;
	logic except_illegal;
	logic sig_syscall;
	logic sig_trap;
	sel_t sel_a;
	sel_t sel_b;
	reg_addr_t rf_addra;
	reg_addr_t rf_addrb;
	logic rf_rda;
	logic rf_rdb;

	string test_name;
	int errors;
	int test_errors;
	int tests_run;
	int tests_failed;
	int checks_done;
	logic chk_on;
	// words still in ID and EX, oldest first
	logic [31:0] in_flight[$];

	decode_ctrl_top dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// expected decode of one word
	function automatic expect_t decode_ref(input logic [31:0] w);
		expect_t e;
		opcode_t op;
		logic [15:0] split;
		op = w[31:26];
		split = {w[25:21], w[10:0]};
		e = '0;
		e.alu_op = ALUOP_NOP;
		e.rf_addrw = w[25:21];
		e.simm = {16'h0000, w[15:0]};
		case (op)
			OP_J, OP_JR, OP_BNF, OP_BF, OP_RFE, OP_NOP: ;
			OP_JAL, OP_JALR: begin
				e.rfwb_op = {RFWB_SRC_LR, 1'b1};
				e.rf_addrw = link_reg;
			end
			OP_XSYNC: begin
				e.syscall = (w[25:23] == 3'b000);
				e.trap = (w[25:23] == 3'b010);
			end
			OP_MOVHI: e.alu_op = ALUOP_MOVHI;
			OP_ADDI: e.alu_op = ALUOP_ADD;
			OP_ADDIC: e.alu_op = ALUOP_ADDC;
			OP_ANDI: e.alu_op = ALUOP_AND;
			OP_ORI: e.alu_op = ALUOP_OR;
			OP_XORI: e.alu_op = ALUOP_XOR;
			OP_LWZ: e.lsu_op = LSU_LWZ;
			OP_LWS: e.lsu_op = LSU_LWS;
			OP_LBZ: e.lsu_op = LSU_LBZ;
			OP_LBS: e.lsu_op = LSU_LBS;
			OP_LHZ: e.lsu_op = LSU_LHZ;
			OP_LHS: e.lsu_op = LSU_LHS;
			OP_MFSPR: e.rfwb_op = {RFWB_SRC_SPRS, 1'b1};
			OP_MTSPR: e.simm = {16'h0000, split};
			OP_SW: e.lsu_op = LSU_SW;
			OP_SB: e.lsu_op = LSU_SB;
			OP_SH: e.lsu_op = LSU_SH;
			OP_SFXX, OP_SFXXI: e.alu_op = ALUOP_COMP;
			OP_ALU: begin
				e.alu_op = {1'b0, w[3:0]};
				e.illegal = (w[4:0] == ALUFN_MUL) || (w[4:0] == ALUFN_DIV) ||
					(w[4:0] == ALUFN_DIVU) ||
					((w[4:0] == ALUFN_SHROT) && (w[9:6] == SHROT_ROR));
			end
			default: e.illegal = 1'b1;
		endcase
		// arithmetic and logic group writes back from the ALU
		if (op inside {OP_MOVHI, OP_ADDI, OP_ADDIC, OP_ANDI, OP_ORI, OP_XORI, OP_ALU})
			e.rfwb_op = {RFWB_SRC_ALU, 1'b1};
		if (op inside {OP_LWZ, OP_LWS, OP_LBZ, OP_LBS, OP_LHZ, OP_LHS}) begin
			e.rfwb_op = {RFWB_SRC_LSU, 1'b1};
			e.simm = {{16{w[15]}}, w[15:0]};
		end
		if (op inside {OP_ADDI, OP_ADDIC, OP_XORI, OP_SFXXI})
			e.simm = {{16{w[15]}}, w[15:0]};
		if (op inside {OP_SW, OP_SB, OP_SH})
			e.simm = {{16{split[15]}}, split};
		return e;
	endfunction

	function automatic branch_op_t branch_ref(input opcode_t op);
		if (op == OP_J || op == OP_JAL)
			return BR_J;
		if (op == OP_JR || op == OP_JALR)
			return BR_JR;
		if (op == OP_BNF)
			return BR_BNF;
		if (op == OP_BF)
			return BR_BF;
		if (op == OP_RFE)
			return BR_RFE;
		return BR_NOP;
	endfunction

	function automatic logic is_kept(input opcode_t op);
		for (int i = 0; i < 29; i++)
			if (kept_ops[i] == op)
				return 1'b1;
		return 1'b0;
	endfunction

	// mostly kept opcodes, some illegal ones, biased toward odd ALU functions
	function automatic logic [31:0] random_word();
		logic [31:0] w;
		opcode_t op;
		w = $urandom;
		if ($urandom_range(7) == 0) begin
			op = 6'($urandom_range(63));
			while (is_kept(op))
				op = 6'($urandom_range(63));
		end else begin
			op = kept_ops[$urandom_range(28)];
		end
		w[31:26] = op;
		if (op == OP_ALU && $urandom_range(1) == 1) begin
			case ($urandom_range(3))
				0: w[4:0] = ALUFN_MUL;
				1: w[4:0] = ALUFN_DIV;
				2: w[4:0] = ALUFN_DIVU;
				default: begin
					w[4:0] = ALUFN_SHROT;
					w[9:6] = SHROT_ROR;
				end
			endcase
		end
		if (op == OP_XSYNC)
			w[25:23] = ($urandom_range(1) == 1) ? 3'b000 : 3'b010;
		return w;
	endfunction

	//////////////////////////////////////////////////////////////////////
	task automatic compare_value(input string what, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		if (exp_v !== act_v) begin
			$display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp_v, act_v);
			errors++;
			test_errors++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		$display("test %-10s %0d mismatches", test_name, test_errors);
	endtask

	// outputs settle shortly after the rising edge
	task automatic settle();
		@(posedge clk);
		#1;
	endtask

	task automatic set_flush(input int src, input logic v);
		case (src)
			0: except_flushpipe = v;
			1: pc_we = v;
			2: extend_flush = v;
			default: du_flush_pipe = v;
		endcase
	endtask

	task automatic wait_for_checks(input int target, input int limit);
		int n;
		n = 0;
		while (checks_done < target && n < limit) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (checks_done < target) begin
			$display("timeout: compare process finished %0d of %0d checks", checks_done, target);
			errors++;
			test_errors++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// compare process for the free-running decode
	initial begin : compare_proc
		expect_t id_e;
		expect_t ex_e;
		logic [31:0] ex_w;
		forever begin
			@(posedge clk);
			#1;
			if (chk_on && in_flight.size() == 2) begin
				ex_w = in_flight[0];
				id_e = decode_ref(in_flight[1]);
				ex_e = decode_ref(ex_w);
				compare_value("id_insn", in_flight[1], id_insn);
				compare_value("id_simm", id_e.simm, id_simm);
				compare_value("id_lsu_op", 32'(id_e.lsu_op), 32'(id_lsu_op));
				compare_value("ex_insn", ex_w, ex_insn);
				compare_value("alu_op", 32'(ex_e.alu_op), 32'(alu_op));
				compare_value("rfwb_op", 32'(ex_e.rfwb_op), 32'(rfwb_op));
				compare_value("rf_addrw", 32'(ex_e.rf_addrw), 32'(rf_addrw));
				compare_value("ex_simm", ex_e.simm, ex_simm);
				compare_value("comp_op", 32'(ex_w[24:21]), 32'(comp_op));
				compare_value("alu_op2", 32'(ex_w[9:6]), 32'(alu_op2));
				compare_value("except_illegal", 32'(ex_e.illegal), 32'(except_illegal));
				compare_value("sig_syscall", 32'(ex_e.syscall), 32'(sig_syscall));
				compare_value("sig_trap", 32'(ex_e.trap), 32'(sig_trap));
				checks_done++;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	initial begin
		logic [31:0] w;
		logic [31:0] pc;
		logic [31:2] tgt;
		logic taken;
		logic [31:0] slot;
		opcode_t op;
		expect_t held;
		rst_n = 1'b0;
		if_insn = nop_insn;
		id_pc = 32'h0;
		id_freeze = 1'b0;
		ex_freeze = 1'b0;
		wb_freeze = 1'b0;
		ex_branch_taken = 1'b0;
		abort_mvspr = 1'b0;
		du_hwbkpt = 1'b0;
		wbforw_valid = 1'b0;
		except_flushpipe = 1'b0;
		pc_we = 1'b0;
		extend_flush = 1'b0;
		du_flush_pipe = 1'b0;
		chk_on = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		checks_done = 0;
		void'($urandom(44));
		repeat (10) @(posedge clk);

		begin_test("reset");
		@(negedge clk);
		compare_value("id_insn", nop_insn, id_insn);
		compare_value("ex_insn", nop_insn, ex_insn);
		compare_value("wb_insn", nop_insn, wb_insn);
		compare_value("id_void", 32'd1, 32'(id_void));
		compare_value("ex_void", 32'd1, 32'(ex_void));
		compare_value("alu_op", 32'(ALUOP_NOP), 32'(alu_op));
		compare_value("rfwb_op", 32'(RFWB_NOP), 32'(rfwb_op));
		compare_value("rf_addrw", 32'd0, 32'(rf_addrw));
		compare_value("id_branch_op", 32'(BR_NOP), 32'(id_branch_op));
		compare_value("ex_branch_op", 32'(BR_NOP), 32'(ex_branch_op));
		compare_value("flags", 32'd0, 32'({except_illegal, sig_syscall, sig_trap}));
		compare_value("spr strobes", 32'd0, 32'({ex_spr_read, ex_spr_write}));
		rst_n = 1'b1;
		finish_test();

		// first word is a JAL so the link register shows up early
		begin_test("decode");
		in_flight.delete();
		checks_done = 0;
		chk_on = 1'b1;
		for (int i = 0; i < 202; i++) begin
			if (i == 0)
				w = {OP_JAL, 26'h0000040};
			else if (i < 200)
				w = random_word();
			else
				w = nop_insn;
			@(negedge clk);
			if_insn = w;
			in_flight.push_back(w);
			if (in_flight.size() > 2)
				void'(in_flight.pop_front());
		end
		wait_for_checks(201, 8);
		chk_on = 1'b0;
		finish_test();

		begin_test("flush");
		for (int k = 0; k < 4; k++) begin
			@(negedge clk);
			if_insn = addi_w;
			@(negedge clk);
			if_insn = ori_w;
			set_flush(k, 1'b1);
			settle();
			compare_value("flushpipe", 32'd1, 32'(flushpipe));
			compare_value("id_insn", nop_insn, id_insn);
			compare_value("ex_insn", nop_insn, ex_insn);
			compare_value("alu_op", 32'(ALUOP_NOP), 32'(alu_op));
			compare_value("rfwb_op", 32'(RFWB_NOP), 32'(rfwb_op));
			compare_value("id_branch_op", 32'(BR_NOP), 32'(id_branch_op));
			@(negedge clk);
			set_flush(k, 1'b0);
		end
		finish_test();

		// ID stall under a running EX, then EX held
		begin_test("freeze");
		held = decode_ref(addi_w);
		@(negedge clk);
		if_insn = addi_w;
		@(negedge clk);
		id_freeze = 1'b1;
		if_insn = ori_w;
		settle();
		compare_value("ex_insn", nop_insn, ex_insn);
		compare_value("alu_op", 32'(ALUOP_NOP), 32'(alu_op));
		compare_value("rfwb_op", 32'(RFWB_NOP), 32'(rfwb_op));
		compare_value("id_insn", addi_w, id_insn);
		@(negedge clk);
		id_freeze = 1'b0;
		settle();
		@(negedge clk);
		ex_freeze = 1'b1;
		if_insn = xori_w;
		repeat (3) begin
			settle();
			compare_value("ex_insn", addi_w, ex_insn);
			compare_value("alu_op", 32'(held.alu_op), 32'(alu_op));
			compare_value("rfwb_op", 32'(held.rfwb_op), 32'(rfwb_op));
			compare_value("rf_addrw", 32'(held.rf_addrw), 32'(rf_addrw));
			compare_value("ex_simm", held.simm, ex_simm);
		end
		@(negedge clk);
		ex_freeze = 1'b0;
		finish_test();

		begin_test("forward");
		@(negedge clk);
		if_insn = addi_w;
		@(negedge clk);
		if_insn = alu1_w;
		settle();
		compare_value("sel_a ex", 32'(SEL_EX_FORW), 32'(sel_a));
		compare_value("sel_b rf", 32'(SEL_RF), 32'(sel_b));
		@(negedge clk);
		if_insn = alu2_w;
		wbforw_valid = 1'b1;
		settle();
		compare_value("sel_a wb", 32'(SEL_WB_FORW), 32'(sel_a));
		compare_value("sel_b rf", 32'(SEL_RF), 32'(sel_b));
		@(negedge clk);
		if_insn = ori_w;
		wbforw_valid = 1'b0;
		settle();
		compare_value("sel_b imm", 32'(SEL_IMM), 32'(sel_b));
		compare_value("rf_addra", 32'(ori_w[20:16]), 32'(rf_addra));
		compare_value("rf_addrb", 32'(ori_w[15:11]), 32'(rf_addrb));
		compare_value("rf_rd", 32'(ori_w[31:30]), 32'({rf_rda, rf_rdb}));
		finish_test();

		// second half puts a bubble in the delay slot
		begin_test("branch");
		for (int i = 0; i < 16; i++) begin
			op = br_ops[i % 8];
			w = {op, 26'($urandom)};
			pc = $urandom;
			tgt = {{4{w[25]}}, w[25:0]} + pc[31:2];
			slot = (i < 8) ? addi_w : nop_insn;
			@(negedge clk);
			if_insn = w;
			id_pc = pc;
			settle();
			compare_value("id_branch_op", 32'(branch_ref(op)), 32'(id_branch_op));
			compare_value("id_target", 32'(tgt), 32'(id_branch_addrtarget));
			compare_value("rfe id", 32'(op == OP_RFE), 32'(rfe));
			taken = ($urandom_range(1) == 1);
			@(negedge clk);
			if_insn = slot;
			ex_branch_taken = taken;
			settle();
			compare_value("ex_branch_op", 32'(branch_ref(op)), 32'(ex_branch_op));
			compare_value("ex_target", 32'(tgt), 32'(ex_branch_addrtarget));
			compare_value("no_more_dslot",
				32'(((branch_ref(op) != BR_NOP) && taken && (slot != nop_insn)) ||
				(op == OP_RFE)),
				32'(no_more_dslot));
			compare_value("rfe ex", 32'(op == OP_RFE), 32'(rfe));
		end
		ex_branch_taken = 1'b0;
		finish_test();

		// two mfspr then two mtspr, abort on every second one in EX
		begin_test("spr_trap");
		for (int i = 0; i < 5; i++) begin
			@(negedge clk);
			if_insn = (i < 2) ? mfspr_w : ((i < 4) ? mtspr_w : addi_w);
			if (i > 0)
				abort_mvspr = ((i - 1) % 2 == 1);
			settle();
			if (i > 0) begin
				compare_value("ex_spr_read", 32'((i - 1 < 2) && !abort_mvspr),
					32'(ex_spr_read));
				compare_value("ex_spr_write", 32'((i - 1 >= 2) && !abort_mvspr),
					32'(ex_spr_write));
			end
		end
		@(negedge clk);
		abort_mvspr = 1'b0;
		du_hwbkpt = 1'b1;
		settle();
		compare_value("sig_trap bkpt", 32'd1, 32'(sig_trap));
		@(negedge clk);
		du_hwbkpt = 1'b0;
		settle();
		compare_value("sig_trap clear", 32'd0, 32'(sig_trap));
		finish_test();

		$display("%0d tests, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== flist.f ====
hw/or_isa_pkg.sv
hw/or_ctrl_pkg.sv
hw/insn_pipe.sv
hw/branch_ctrl.sv
hw/id_decode.sv
hw/operand_forward.sv
hw/decode_ctrl_top.sv
tb/decode_ctrl_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the decode control testbench, pass only on the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps -f flist.f --top-module decode_ctrl_tb \
	-o decode_ctrl_sim \
	&& ./obj_dir/decode_ctrl_sim 2>&1 | tee sim.log \
	&& grep -q "TEST PASSED" sim.log || exit 1
